/* hdl/core_defs.svh */
/*
 * shared constants for the core shell
 * raster geometry, sync column and test-field bounds
 * fractional accumulator steps for pixel strobe and audio mclk
 * audio sample and slot widths, default throttle divisor
 */

`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// raster geometry

// 400 clocks per line, 320 visible
`define CORE_H_TOTAL        400
`define CORE_H_BPORCH       10
`define CORE_H_ACTIVE       320

// 512 lines per frame, 240 visible
`define CORE_V_TOTAL        512
`define CORE_V_BPORCH       10
`define CORE_V_ACTIVE       240

// hsync sits a few pixels after vsync
`define CORE_HS_X           3

// test field
`define CORE_RED_X_LIMIT    60
`define CORE_RED_Y_LIMIT    200
`define CORE_GREY_LEVEL     60

////////////////////////////////////////////////////////////////////////////
// rate generation from the 74.25 MHz clock

// pixel strobe near 12.288 MHz
`define CORE_PIX_STEP       12288
`define CORE_PIX_MOD        74250

// mclk toggle rate, twice 12.288 MHz
`define CORE_MCLK_STEP      245760
`define CORE_MCLK_MOD       742500

// audio framing
`define CORE_SAMPLE_W       16
`define CORE_SLOT_BITS      32

// roughly 2 Hz processor step
`define CORE_THROTTLE_DIV   37000000

`endif

/* hdl/video_pkg.sv */
/*
 * video types
 * raster coordinate and packed rgb pixel
 */

package video_pkg;

    ////////////////////////////////////////////////////////////////////////
    // coordinates

    // wide enough for the 512 line grid
    typedef logic [9:0] coord_t;

    ////////////////////////////////////////////////////////////////////////
    // pixel

    // r in the top byte, b in the bottom byte
    // matches the 24-bit scaler bus order
    typedef struct packed {
        // red channel
        logic [7:0] r;
        // green channel
        logic [7:0] g;
        // blue channel
        logic [7:0] b;
    } rgb_t;

endpackage

/* hdl/audio_pkg.sv */
/*
 * audio types
 * i2s framer states and bit-slot index
 */

package audio_pkg;

    // one channel slot is 16 data bits then 16 pad bits
    // left half first, lrck low
    typedef enum logic [1:0] {
        LEFT_DATA  = 2'd0,
        LEFT_PAD   = 2'd1,
        RIGHT_DATA = 2'd2,
        RIGHT_PAD  = 2'd3
    } i2s_state_e;

    // bit index within a 32 bit slot
    // wraps naturally at the end of a channel
    typedef logic [4:0] slot_t;

endpackage

/* hdl/rate_gen.sv */
/*
 * rate generator on clk_74a
 * pixel strobe and audio mclk from fractional accumulators
 * sclk and its falling strobe, throttle step strobe
 */

`include "core_defs.svh"

module rate_gen #(
    parameter int unsigned throttle_div = `CORE_THROTTLE_DIV
) (
    input  logic clk_74a,
    input  logic reset_n,
    output logic pix_en,
    output logic audio_mclk,
    output logic audio_sclk,
    output logic sclk_fall,
    output logic cpu_tick
);

    localparam int unsigned PIX_W  = 17;
    localparam int unsigned MCLK_W = 20;
    localparam int unsigned THR_W  = (throttle_div > 1) ? $clog2(throttle_div) : 1;

    logic [PIX_W-1:0]  pix_acc;
    logic [MCLK_W-1:0] mclk_acc;
    logic              mclk_wrap;
    logic [1:0]        sclk_cnt;
    logic [THR_W-1:0]  thr_cnt;

    ////////////////////////////////////////////////////////////////////////
    // pixel strobe

    // one pulse every 6 or 7 clocks
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            pix_acc <= '0;
            pix_en  <= 1'b0;
        end else if (pix_acc >= PIX_W'(`CORE_PIX_MOD)) begin
            pix_acc <= pix_acc - PIX_W'(`CORE_PIX_MOD) + PIX_W'(`CORE_PIX_STEP);
            pix_en  <= 1'b1;
        end else begin
            pix_acc <= pix_acc + PIX_W'(`CORE_PIX_STEP);
            pix_en  <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // audio clocks

    assign mclk_wrap  = (mclk_acc >= MCLK_W'(`CORE_MCLK_MOD));
    // sclk is mclk divided by 4
    assign audio_sclk = sclk_cnt[1];

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            mclk_acc   <= '0;
            audio_mclk <= 1'b0;
            sclk_cnt   <= 2'd0;
            sclk_fall  <= 1'b0;
        end else begin
            sclk_fall <= 1'b0;
            if (mclk_wrap) begin
                mclk_acc   <= mclk_acc - MCLK_W'(`CORE_MCLK_MOD) + MCLK_W'(`CORE_MCLK_STEP);
                audio_mclk <= ~audio_mclk;
                // mclk about to rise
                if (!audio_mclk) begin
                    sclk_cnt  <= sclk_cnt + 2'd1;
                    // 3 to 0 drops sclk
                    sclk_fall <= (sclk_cnt == 2'd3);
                end
            end else begin
                mclk_acc <= mclk_acc + MCLK_W'(`CORE_MCLK_STEP);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // throttle

    // first tick lands throttle_div clocks after reset release
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            thr_cnt  <= '0;
            cpu_tick <= 1'b0;
        end else if (thr_cnt == THR_W'(throttle_div - 1)) begin
            thr_cnt  <= '0;
            cpu_tick <= 1'b1;
        end else begin
            thr_cnt  <= thr_cnt + 1'b1;
            cpu_tick <= 1'b0;
        end
    end

endmodule

/* hdl/raster_timing.sv */
/*
 * raster position counters
 * x wraps at the end of a line, y at the end of a frame
 * both advance only on the pixel strobe
 */

`include "core_defs.svh"

module raster_timing (
    input  logic              clk_74a,
    input  logic              reset_n,
    input  logic              pix_en,
    output video_pkg::coord_t x_pos,
    output video_pkg::coord_t y_pos
);

    // last column and last line of the grid
    localparam video_pkg::coord_t H_LAST = video_pkg::coord_t'(`CORE_H_TOTAL - 1);
    localparam video_pkg::coord_t V_LAST = video_pkg::coord_t'(`CORE_V_TOTAL - 1);

    logic x_at_end;
    logic y_at_end;

    ////////////////////////////////////////////////////////////////////////
    // wrap detection

    assign x_at_end = (x_pos == H_LAST);
    assign y_at_end = (y_pos == V_LAST);

    ////////////////////////////////////////////////////////////////////////
    // horizontal counter

    // 400 pixel periods per line
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            x_pos <= '0;
        end else if (pix_en) begin
            if (x_at_end) begin
                x_pos <= '0;
            end else begin
                x_pos <= x_pos + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // vertical counter

    // steps once per line
    // 512 lines per frame
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            y_pos <= '0;
        end else if (pix_en && x_at_end) begin
            if (y_at_end) begin
                y_pos <= '0;
            end else begin
                y_pos <= y_pos + 1'b1;
            end
        end
    end

endmodule

/* hdl/pixel_pattern.sv */
/*
 * test field generator
 * registered sync, data enable and colour from raster position
 * grey field, partly red when the processor status word is 1
 */

`include "core_defs.svh"

module pixel_pattern (
    input  logic              clk_74a,
    input  logic              reset_n,
    input  logic              pix_en,
    input  video_pkg::coord_t x_pos,
    input  video_pkg::coord_t y_pos,
    input  logic [31:0]       cpu_status,
    output video_pkg::rgb_t   video_rgb,
    output logic              video_de,
    output logic              video_hs,
    output logic              video_vs
);

    // active window is x 10..329 and y 10..249
    localparam video_pkg::coord_t H_START = video_pkg::coord_t'(`CORE_H_BPORCH);
    localparam video_pkg::coord_t H_END   = video_pkg::coord_t'(`CORE_H_BPORCH + `CORE_H_ACTIVE);
    localparam video_pkg::coord_t V_START = video_pkg::coord_t'(`CORE_V_BPORCH);
    localparam video_pkg::coord_t V_END   = video_pkg::coord_t'(`CORE_V_BPORCH + `CORE_V_ACTIVE);
    localparam video_pkg::coord_t HS_X    = video_pkg::coord_t'(`CORE_HS_X);
    localparam video_pkg::coord_t RED_X   = video_pkg::coord_t'(`CORE_RED_X_LIMIT);
    localparam video_pkg::coord_t RED_Y   = video_pkg::coord_t'(`CORE_RED_Y_LIMIT);
    localparam logic [7:0]        GREY    = 8'(`CORE_GREY_LEVEL);

    logic            in_window;
    logic            red_zone;
    video_pkg::rgb_t pix_colour;

    ////////////////////////////////////////////////////////////////////////
    // decode

    assign in_window = (x_pos >= H_START) && (x_pos < H_END) &&
                       (y_pos >= V_START) && (y_pos < V_END);
    // left band and bottom band
    assign red_zone  = (cpu_status == 32'd1) && ((x_pos < RED_X) || (y_pos > RED_Y));

    // black outside the window
    always_comb begin
        pix_colour = '0;
        if (in_window) begin
            if (red_zone) begin
                pix_colour.r = 8'd255;
            end else begin
                pix_colour.r = GREY;
                pix_colour.g = GREY;
                pix_colour.b = GREY;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // output registers

    // held for a full pixel period
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
        end else if (pix_en) begin
            video_rgb <= pix_colour;
            video_de  <= in_window;
            video_hs  <= (x_pos == HS_X);
            // new frame at the origin
            video_vs  <= (x_pos == '0) && (y_pos == '0);
        end
    end

endmodule

/* hdl/i2s_framer.sv */
/*
 * i2s transmitter
 * 32 bit slot per channel, sample msb first then zero pad
 * lrck low for left, high for right
 */

`include "core_defs.svh"

module i2s_framer (
    input  logic                      clk_74a,
    input  logic                      reset_n,
    input  logic                      sclk_fall,
    input  logic [`CORE_SAMPLE_W-1:0] sample_l,
    input  logic [`CORE_SAMPLE_W-1:0] sample_r,
    output logic                      audio_lrck,
    output logic                      audio_dac
);

    localparam audio_pkg::slot_t DATA_LAST = audio_pkg::slot_t'(`CORE_SAMPLE_W - 1);
    localparam audio_pkg::slot_t SLOT_LAST = audio_pkg::slot_t'(`CORE_SLOT_BITS - 1);

    audio_pkg::i2s_state_e     state_q;
    audio_pkg::slot_t          slot_q;
    logic [`CORE_SAMPLE_W-1:0] shift_q;
    logic [`CORE_SAMPLE_W-1:0] sample_sel;
    logic [`CORE_SAMPLE_W-1:0] data_word;
    logic                      right_half;

    ////////////////////////////////////////////////////////////////////////
    // data path

    assign right_half = (state_q == audio_pkg::RIGHT_DATA) || (state_q == audio_pkg::RIGHT_PAD);
    assign sample_sel = right_half ? sample_r : sample_l;
    // slot 0 takes a fresh sample
    assign data_word  = (slot_q == '0) ? sample_sel : shift_q;

    always_ff @(posedge clk_74a) begin
        if (sclk_fall) begin
            shift_q <= {data_word[`CORE_SAMPLE_W-2:0], 1'b0};
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // slot fsm

    // state and slot name the bit driven on the next sclk fall
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= audio_pkg::LEFT_DATA;
            slot_q     <= '0;
            audio_lrck <= 1'b0;
            audio_dac  <= 1'b0;
        end else if (sclk_fall) begin
            slot_q     <= slot_q + 1'b1;
            // lrck follows the half that owns this bit
            audio_lrck <= right_half;
            case (state_q)
                audio_pkg::LEFT_DATA, audio_pkg::RIGHT_DATA: begin
                    audio_dac <= data_word[`CORE_SAMPLE_W-1];
                    if (slot_q == DATA_LAST) begin
                        state_q <= right_half ? audio_pkg::RIGHT_PAD : audio_pkg::LEFT_PAD;
                    end
                end
                default: begin
                    // zero pad to the end of the slot
                    audio_dac <= 1'b0;
                    if (slot_q == SLOT_LAST) begin
                        state_q <= right_half ? audio_pkg::LEFT_DATA : audio_pkg::RIGHT_DATA;
                    end
                end
            endcase
        end
    end

endmodule

/* hdl/core_top.sv */
/*
 * core shell top level
 * rate generator, raster counters, test field and i2s framer
 */

`include "core_defs.svh"

module core_top #(
    parameter int unsigned throttle_div = `CORE_THROTTLE_DIV
) (
    input  logic                      clk_74a,
    input  logic                      reset_n,
    input  logic [31:0]               cpu_status,
    input  logic [`CORE_SAMPLE_W-1:0] sample_l,
    input  logic [`CORE_SAMPLE_W-1:0] sample_r,
    output video_pkg::rgb_t           video_rgb,
    output logic                      video_de,
    output logic                      video_hs,
    output logic                      video_vs,
    output logic                      audio_mclk,
    output logic                      audio_sclk,
    output logic                      audio_lrck,
    output logic                      audio_dac,
    output logic                      cpu_tick
);

    logic              pix_en;
    logic              sclk_fall;
    video_pkg::coord_t x_pos;
    video_pkg::coord_t y_pos;

    ////////////////////////////////////////////////////////////////////////
    // clock rates

    rate_gen #(
        .throttle_div (throttle_div)
    ) rate_gen_inst (
        .clk_74a    (clk_74a),
        .reset_n    (reset_n),
        .pix_en     (pix_en),
        .audio_mclk (audio_mclk),
        .audio_sclk (audio_sclk),
        .sclk_fall  (sclk_fall),
        .cpu_tick   (cpu_tick)
    );

    ////////////////////////////////////////////////////////////////////////
    // video

    raster_timing raster_timing_inst (
        .clk_74a (clk_74a),
        .reset_n (reset_n),
        .pix_en  (pix_en),
        .x_pos   (x_pos),
        .y_pos   (y_pos)
    );

    pixel_pattern pixel_pattern_inst (
        .clk_74a    (clk_74a),
        .reset_n    (reset_n),
        .pix_en     (pix_en),
        .x_pos      (x_pos),
        .y_pos      (y_pos),
        .cpu_status (cpu_status),
        .video_rgb  (video_rgb),
        .video_de   (video_de),
        .video_hs   (video_hs),
        .video_vs   (video_vs)
    );

    ////////////////////////////////////////////////////////////////////////
    // audio

    i2s_framer i2s_framer_inst (
        .clk_74a    (clk_74a),
        .reset_n    (reset_n),
        .sclk_fall  (sclk_fall),
        .sample_l   (sample_l),
        .sample_r   (sample_r),
        .audio_lrck (audio_lrck),
        .audio_dac  (audio_dac)
    );

endmodule

/* testbench/tb_clock.sv */
/*
 * clock and reset source for the testbench
 * 4 ns clk_74a, reset_n held low for the first cycles
 */

module tb_clock #(
    parameter int unsigned reset_cycles = 3
) (
    output logic clk_74a,
    output logic reset_n
);

    timeunit 1ns;
    timeprecision 1ps;

    // 250 MHz stand-in for the 74.25 MHz board clock
    initial begin
        clk_74a = 1'b0;
        forever #2 clk_74a = ~clk_74a;
    end

    // release lands on a rising edge
    initial begin
        reset_n = 1'b0;
        repeat (reset_cycles) @(posedge clk_74a);
        reset_n <= 1'b1;
    end

endmodule

/* testbench/tb_core_top.sv */
/*
 * testbench for the core shell top level
 * reset values, throttle strobe, raster counts, test field colours
 * i2s frames of random samples
 */

module tb_core_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned THROTTLE = 10;
    localparam logic [23:0] GREY_RGB = {8'd60, 8'd60, 8'd60};
    localparam logic [23:0] RED_RGB  = {8'd255, 8'd0, 8'd0};
    // a frame is about 1.24 million clocks
    localparam int FRAME_GUARD = 2_600_000;
    // an lrck half is about 770 clocks
    localparam int HALF_GUARD  = 1_000;

    logic            clk_74a;
    logic            reset_n;
    logic [31:0]     cpu_status;
    logic [15:0]     sample_l;
    logic [15:0]     sample_r;
    video_pkg::rgb_t video_rgb;
    logic            video_de;
    logic            video_hs;
    logic            video_vs;
    logic            audio_mclk;
    logic            audio_sclk;
    logic            audio_lrck;
    logic            audio_dac;
    logic            cpu_tick;

    int errors;
    int colour_errors;
    int tests_run;
    int tests_failed;
    int grey_checks;
    bit video_check_on;
    bit red_seen;
    bit grey_seen_red_mode;

    tb_clock #(
        .reset_cycles (3)
    ) clock_gen_inst (
        .clk_74a (clk_74a),
        .reset_n (reset_n)
    );

    core_top #(
        .throttle_div (THROTTLE)
    ) core_top_inst (
        .clk_74a    (clk_74a),
        .reset_n    (reset_n),
        .cpu_status (cpu_status),
        .sample_l   (sample_l),
        .sample_r   (sample_r),
        .video_rgb  (video_rgb),
        .video_de   (video_de),
        .video_hs   (video_hs),
        .video_vs   (video_vs),
        .audio_mclk (audio_mclk),
        .audio_sclk (audio_sclk),
        .audio_lrck (audio_lrck),
        .audio_dac  (audio_dac),
        .cpu_tick   (cpu_tick)
    );

    ////////////////////////////////////////////////////////////////////////////
    // checking and reporting

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] t=%0d ns %s: expected %0h, got %0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("error at %0d ns: %s", $time, what);
        errors++;
    endtask

    // errors outside the colour monitor
    function automatic int own_errors();
        return errors - colour_errors;
    endfunction

    task automatic print_result(input string name, input int fails);
        tests_run++;
        if (fails == 0) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, fails);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // colour monitor

    // sampled mid-cycle, away from the rising edge
    always @(negedge clk_74a) begin
        if (video_check_on && video_de) begin
            if (cpu_status == 32'd0) begin
                grey_checks++;
                assert (video_rgb === GREY_RGB) else begin
                    $display("[FAIL] t=%0d ns video_rgb: expected %0h, got %0h",
                             $time, GREY_RGB, video_rgb);
                    errors++;
                    colour_errors++;
                end
            end else begin
                assert (video_rgb === GREY_RGB || video_rgb === RED_RGB) else begin
                    $display("[FAIL] t=%0d ns video_rgb: expected %0h or %0h, got %0h",
                             $time, GREY_RGB, RED_RGB, video_rgb);
                    errors++;
                    colour_errors++;
                end
                if (video_rgb === RED_RGB) begin
                    red_seen = 1'b1;
                end
                // grey after red, so not a stale pixel from before the switch
                if (video_rgb === GREY_RGB && red_seen) begin
                    grey_seen_red_mode = 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tests

    task automatic quiet_outputs();
        check_value("video_rgb", 32'd0, video_rgb);
        check_value("video_de", 32'd0, video_de);
        check_value("video_hs", 32'd0, video_hs);
        check_value("video_vs", 32'd0, video_vs);
        check_value("audio_lrck", 32'd0, audio_lrck);
        check_value("audio_dac", 32'd0, audio_dac);
        check_value("cpu_tick", 32'd0, cpu_tick);
    endtask

    task automatic reset_values();
        int base;
        int guard;
        base = own_errors();
        guard = 0;
        // wait past the first rising edge
        @(posedge clk_74a);
        @(negedge clk_74a);
        while (reset_n !== 1'b1 && guard < 20) begin
            quiet_outputs();
            guard++;
            @(negedge clk_74a);
        end
        if (reset_n !== 1'b1) begin
            report_error("reset_n was never released");
        end
        // first cycle out of reset, before and after its first clock edge
        quiet_outputs();
        @(negedge clk_74a);
        quiet_outputs();
        print_result("reset values", own_errors() - base);
    endtask

    task automatic tick_spacing();
        int base;
        int guard;
        int gap;
        int pulses;
        base = own_errors();
        guard = 0;
        gap = 0;
        pulses = 0;
        while (pulses < 8 && guard < 200) begin
            @(negedge clk_74a);
            guard++;
            gap++;
            if (cpu_tick) begin
                if (pulses > 0) begin
                    check_value("cpu_tick period", THROTTLE, gap);
                end
                pulses++;
                gap = 1;
                @(negedge clk_74a);
                guard++;
                // one cycle wide
                check_value("cpu_tick", 32'd0, cpu_tick);
            end
        end
        if (pulses < 8) begin
            report_error("timeout: too few cpu_tick pulses within 200 clocks");
        end
        print_result("throttle strobe", own_errors() - base);
    endtask

    // one full frame between two vsync rises, cpu_status still 0
    task automatic frame_counts();
        int   base;
        int   guard;
        int   hs_edges;
        int   de_edges;
        logic vs_q;
        logic hs_q;
        logic de_q;
        bit   started;
        bit   done;
        base = own_errors();
        guard = 0;
        hs_edges = 0;
        de_edges = 0;
        vs_q = video_vs;
        hs_q = video_hs;
        de_q = video_de;
        started = 1'b0;
        done = 1'b0;
        while (!done && guard < FRAME_GUARD) begin
            @(negedge clk_74a);
            guard++;
            if (video_vs && !vs_q) begin
                done = started;
                started = 1'b1;
            end
            if (started && !done) begin
                if (video_hs && !hs_q) begin
                    hs_edges++;
                end
                if (video_de && !de_q) begin
                    de_edges++;
                end
            end
            vs_q = video_vs;
            hs_q = video_hs;
            de_q = video_de;
        end
        if (!done) begin
            report_error("timeout: no two rising edges of video_vs");
        end else begin
            check_value("video_hs rises per frame", 32'd512, hs_edges);
            check_value("video_de rises per frame", 32'd240, de_edges);
        end
        print_result("raster counts", own_errors() - base);
    endtask

    task automatic field_colours();
        int base;
        int guard;
        base = own_errors();
        if (grey_checks == 0) begin
            report_error("no active pixels were seen with cpu_status at 0");
        end
        @(posedge clk_74a);
        cpu_status <= 32'd1;
        guard = 0;
        while (!(red_seen && grey_seen_red_mode) && guard < FRAME_GUARD) begin
            @(negedge clk_74a);
            guard++;
        end
        if (!red_seen) begin
            report_error("timeout: no red pixel after cpu_status went to 1");
        end else if (!grey_seen_red_mode) begin
            report_error("timeout: no grey pixel after the red area");
        end
        video_check_on = 1'b0;
        print_result("test field colours", own_errors() - base + colour_errors);
    endtask

    task automatic compare_half(input logic lrck, input int bits, input logic [31:0] word);
        logic [31:0] expected;
        // sample msb first, then 16 zero bits
        expected = lrck ? {sample_r, 16'h0000} : {sample_l, 16'h0000};
        check_value("bits per lrck half", 32'd32, bits);
        check_value(lrck ? "audio_dac right slot" : "audio_dac left slot", expected, word);
    endtask

    // bits sampled on sclk rises, halves split at lrck changes
    task automatic capture_halves(input int n_halves);
        logic        sclk_q;
        logic        lrck_q;
        logic        mclk_q;
        logic        half_lrck;
        logic [31:0] word;
        int          bits;
        int          flips;
        int          halves;
        int          guard;
        int          mclk_rises;
        bit          collecting;
        bit          sclk_seen;
        sclk_q = audio_sclk;
        lrck_q = audio_lrck;
        mclk_q = audio_mclk;
        half_lrck = 1'b0;
        word = '0;
        bits = 0;
        flips = 0;
        halves = 0;
        guard = 0;
        mclk_rises = 0;
        collecting = 1'b0;
        sclk_seen = 1'b0;
        while (halves < n_halves && guard < (n_halves + 3) * HALF_GUARD) begin
            @(negedge clk_74a);
            guard++;
            // sclk is mclk divided by four
            if (audio_mclk && !mclk_q) begin
                mclk_rises++;
            end
            if (audio_sclk && !sclk_q) begin
                if (sclk_seen) begin
                    check_value("audio_mclk rises per audio_sclk period", 32'd4, mclk_rises);
                end
                sclk_seen = 1'b1;
                mclk_rises = 0;
                if (audio_lrck !== lrck_q) begin
                    if (collecting) begin
                        compare_half(half_lrck, bits, word);
                        halves++;
                    end
                    flips++;
                    // first half after a sample change may hold old data
                    if (flips >= 2) begin
                        collecting = 1'b1;
                        half_lrck = audio_lrck;
                        word = '0;
                        bits = 0;
                    end
                end
                if (collecting) begin
                    word = {word[30:0], audio_dac};
                    bits++;
                end
                lrck_q = audio_lrck;
            end
            mclk_q = audio_mclk;
            sclk_q = audio_sclk;
        end
        if (halves < n_halves) begin
            report_error("timeout: audio_lrck halves did not complete");
        end
    endtask

    task automatic i2s_frames();
        int base;
        base = own_errors();
        repeat (2) begin
            @(posedge clk_74a);
            sample_l <= 16'($urandom);
            sample_r <= 16'($urandom);
            capture_halves(4);
        end
        print_result("i2s frames", own_errors() - base);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sequence

    initial begin
        errors = 0;
        colour_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        grey_checks = 0;
        video_check_on = 1'b0;
        red_seen = 1'b0;
        grey_seen_red_mode = 1'b0;
        cpu_status = '0;
        sample_l = '0;
        sample_r = '0;
        void'($urandom(32'he156));

        reset_values();
        tick_spacing();
        video_check_on = 1'b1;
        frame_counts();
        field_colours();
        i2s_frames();

        $display("tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+hdl
hdl/video_pkg.sv
hdl/audio_pkg.sv
hdl/rate_gen.sv
hdl/raster_timing.sv
hdl/pixel_pattern.sv
hdl/i2s_framer.sv
hdl/core_top.sv
testbench/tb_clock.sv
testbench/tb_core_top.sv

/* Bender.yml */
package:
  name: core_shell

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/video_pkg.sv
      - hdl/audio_pkg.sv
      - hdl/rate_gen.sv
      - hdl/raster_timing.sv
      - hdl/pixel_pattern.sv
      - hdl/i2s_framer.sv
      - hdl/core_top.sv

  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_core_top.sv
